//--- include/poly_settings.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Polynomial coprocessor sizes and limits.
// Shared by the package and the RTL blocks.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef POLY_SETTINGS_SVH
`define POLY_SETTINGS_SVH

// Datapath widths.
`define POLY_WORD_SIZE 16          // Bits per coefficient.

// Memory sizes.
`define POLY_BUF_DEPTH 1024        // Words in the host data buffer.
`define POLY_SLOTS 8               // Polynomials held at once.
`define POLY_SLOT_WORDS 11         // Coefficient words reserved per slot.

// Instruction limits.
`define POLY_MAX_DEGREE 10         // Largest degree STP will accept.

// Result and status queues.
`define POLY_FIFO_DEPTH 16         // Words per FIFO.

`endif

//--- source/poly_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Polynomial coprocessor package.
// Data types and status codes for all blocks.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "poly_settings.svh"

package poly_pkg;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data types.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [`POLY_WORD_SIZE-1:0] coeff_t;                  // One coefficient.
	typedef logic [4:0] degree_t;                                  // Degree as issued.
	typedef logic [$clog2(`POLY_SLOTS)-1:0] slot_t;                // Slot index A.
	typedef logic [$clog2(`POLY_BUF_DEPTH)-1:0] buf_addr_t;        // Buffer address.

	// Coefficient RAM address, slots times words per slot.
	typedef logic [$clog2(`POLY_SLOTS * `POLY_SLOT_WORDS)-1:0] s_addr_t;

	typedef logic [31:0] fifo_word_t;                              // Result or status word.

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Status codes.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam fifo_word_t STATUS_OK = 32'h0000_0000;              // Instruction completed.
	localparam fifo_word_t STATUS_BAD_DEGREE = 32'h0000_0001;      // Degree above limit.
	localparam fifo_word_t STATUS_IDLE = 32'hffff_ffff;            // Nothing run since reset.

endpackage

//--- source/poly_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simple dual port RAM.
// One write port, one registered read port.
// Payload type is set per instance.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "poly_settings.svh"

module poly_ram #(
	parameter type payload_t = poly_pkg::coeff_t,             // Word type stored.
	parameter int  DEPTH     = `POLY_BUF_DEPTH                // Number of words.
) (
	input  logic                     clk,
	input  logic                     wr_en,                   // Write strobe.
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  payload_t                 wr_data,
	input  logic                     rd_en,                   // Read strobe.
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output payload_t                 rd_data                  // Valid one cycle after rd_en.
);

	payload_t mem [DEPTH];                                   // Storage array.

	// Write port.
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;                       // Store word.
	end

	// Read port, data held until the next read.
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];                       // Registered read.
	end

	// Address range guard for depths that are not a power of two.
	a_wr_addr_range: assert property (@(posedge clk) wr_en |-> (wr_addr < DEPTH))
		else $error("poly_ram write address %0d beyond depth %0d", wr_addr, DEPTH);

endmodule

//--- source/poly_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result and status word FIFO.
// Circular buffer, head word shown combinationally.
// Pushes while full are dropped.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "poly_settings.svh"

module poly_fifo #(
	parameter int DEPTH = `POLY_FIFO_DEPTH                    // Words held.
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 push,                        // Write strobe.
	input  poly_pkg::fifo_word_t push_data,
	input  logic                 pop,                         // Remove head word.
	output poly_pkg::fifo_word_t head_data,                   // Oldest word.
	output logic                 empty
);
	import poly_pkg::*;

	localparam int PTR_BITS = $clog2(DEPTH);                 // Pointer width.
	localparam int CNT_BITS = $clog2(DEPTH + 1);             // Count reaches DEPTH.

	fifo_word_t          mem [DEPTH];                        // Word storage.
	logic [PTR_BITS-1:0] rd_ptr;                             // Head position.
	logic [PTR_BITS-1:0] wr_ptr;                             // Next free position.
	logic [CNT_BITS-1:0] count;                              // Words held.
	logic                full;
	logic                do_push;
	logic                do_pop;

	// Pointer advance with wrap at DEPTH.
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full      = (count == CNT_BITS'(DEPTH));
	assign empty     = (count == '0);
	assign do_push   = push && !full;                        // Drop when full.
	assign do_pop    = pop && !empty;                        // Ignore when empty.
	assign head_data = mem[rd_ptr];

	// Storage write.
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	// Pointers and fill count.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;      // Push only.
				2'b01:   count <= count - 1'b1;      // Pop only.
				default: count <= count;             // Both or neither.
			endcase
		end
	end

	a_push_full: assert property (@(posedge clk) disable iff (!rst) push |-> !full)
		else $error("poly_fifo push while full, word dropped");
	a_pop_empty: assert property (@(posedge clk) disable iff (!rst) pop |-> !empty)
		else $error("poly_fifo pop while empty");

endmodule

//--- source/stp_engine.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// STP execution engine.
// Checks the degree, writes the degree RAM and copies
// N+1 buffer words into the slot, then reports.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "poly_settings.svh"

module stp_engine (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 go,                          // Start pulse from dispatch.
	input  poly_pkg::slot_t      slot,                        // Target slot A.
	input  poly_pkg::degree_t    degree,                      // Degree N.
	input  poly_pkg::buf_addr_t  cursor,                      // First buffer word.
	input  poly_pkg::coeff_t     buf_rd_data,                 // Buffer read return.
	output logic                 buf_rd_en,
	output poly_pkg::buf_addr_t  buf_rd_addr,
	output logic                 s_wr_en,
	output poly_pkg::s_addr_t    s_wr_addr,
	output poly_pkg::coeff_t     s_wr_data,
	output logic                 n_wr_en,
	output poly_pkg::slot_t      n_wr_addr,
	output poly_pkg::degree_t    n_wr_data,
	output logic                 result_push,
	output logic                 status_push,
	output poly_pkg::fifo_word_t result_word,
	output poly_pkg::fifo_word_t status_word,
	output logic                 done,                        // One cycle, end of STP.
	output poly_pkg::buf_addr_t  cursor_next                  // Cursor after this STP.
);
	import poly_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,                                         // Waiting for go.
		ST_CHECK,                                        // Degree test.
		ST_FIRST_READ,                                   // Degree write, first read.
		ST_COPY,                                         // One coefficient per cycle.
		ST_ERROR,                                        // Illegal degree.
		ST_END                                           // Push words, pulse done.
	} state_t;

	state_t     state;
	state_t     state_nxt;
	buf_addr_t  rd_ptr;                                      // Next buffer address.
	s_addr_t    slot_base;                                   // Slot times 11.
	s_addr_t    offset;                                      // Coefficient being written.
	fifo_word_t result_q;
	fifo_word_t status_q;
	logic       bad_degree;
	logic       last_word;

	assign bad_degree = (degree > degree_t'(`POLY_MAX_DEGREE));
	assign last_word  = (offset == s_addr_t'(degree));       // Offset N reached.

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
			begin
				if (go)
					state_nxt = ST_CHECK;
			end
			ST_CHECK:
			begin
				if (bad_degree)
					state_nxt = ST_ERROR;
				else
					state_nxt = ST_FIRST_READ;
			end
			ST_FIRST_READ:
				state_nxt = ST_COPY;
			ST_COPY:
			begin
				if (last_word)
					state_nxt = ST_END;       // All N+1 written.
			end
			ST_ERROR:
				state_nxt = ST_END;
			default:
				state_nxt = ST_IDLE;              // End and illegal codes.
		endcase
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State and working registers.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state     <= ST_IDLE;
			rd_ptr    <= '0;
			slot_base <= '0;
			offset    <= '0;
			result_q  <= '0;
			status_q  <= STATUS_IDLE;                // No instruction yet.
		end
		else
		begin
			state <= state_nxt;
			if (state == ST_IDLE && go)
				rd_ptr <= cursor;                    // Snapshot of the cursor.
			else if (buf_rd_en)
				rd_ptr <= rd_ptr + buf_addr_t'(1);   // Step per read.
			if (state == ST_FIRST_READ)
			begin
				slot_base <= s_addr_t'(slot) * s_addr_t'(`POLY_SLOT_WORDS);
				offset    <= '0;
				result_q  <= fifo_word_t'(1);        // Success.
				status_q  <= STATUS_OK;
			end
			if (state == ST_COPY && !last_word)
				offset <= offset + s_addr_t'(1);
			if (state == ST_ERROR)
			begin
				result_q <= '0;                      // Failure.
				status_q <= STATUS_BAD_DEGREE;
			end
		end
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Outputs, decoded from state.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Read ahead stops once offset N is on the write side.
	assign buf_rd_en   = (state == ST_FIRST_READ) || (state == ST_COPY && !last_word);
	assign buf_rd_addr = rd_ptr;
	assign s_wr_en     = (state == ST_COPY);
	assign s_wr_addr   = slot_base + offset;
	assign s_wr_data   = buf_rd_data;                        // Word read last cycle.
	assign n_wr_en     = (state == ST_FIRST_READ);
	assign n_wr_addr   = slot;
	assign n_wr_data   = degree;
	assign result_push = (state == ST_END);
	assign status_push = (state == ST_END);
	assign result_word = result_q;
	assign status_word = status_q;
	assign done        = (state == ST_END);
	assign cursor_next = rd_ptr;                             // Unmoved on error.

	// An illegal degree leaves both RAMs untouched up to done.
	a_no_write_on_error: assert property (@(posedge clk) disable iff (!rst)
		(state == ST_CHECK && bad_degree) |=> (!s_wr_en && !n_wr_en) until_with done)
		else $error("stp_engine wrote a RAM for an illegal degree");

endmodule

//--- source/poly_dispatch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// STP dispatch.
// Accepts start pulses when idle, holds the operands,
// tracks busy and owns the buffer cursor.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module poly_dispatch (
	input  logic                clk,
	input  logic                rst,
	input  logic                stp_start,                    // Host issue pulse.
	input  poly_pkg::slot_t     stp_slot,
	input  poly_pkg::degree_t   stp_degree,
	input  logic                cursor_clr,                   // Rewind cursor to 0.
	input  logic                done,                         // Engine finished.
	input  poly_pkg::buf_addr_t cursor_next,
	output logic                go,                           // Engine start.
	output poly_pkg::slot_t     slot,
	output poly_pkg::degree_t   degree,
	output poly_pkg::buf_addr_t cursor,
	output logic                busy
);

	logic accept;

	assign accept = stp_start && !busy;                      // Drop starts while busy.

	// Busy flag, go pulse and cursor.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy   <= 1'b0;
			go     <= 1'b0;
			cursor <= '0;
		end
		else
		begin
			go <= accept;                            // One cycle after accept.
			if (accept)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
			if (cursor_clr)
				cursor <= '0;                        // Host rewind wins.
			else if (done)
				cursor <= cursor_next;
		end
	end

	// Operands, stable for the whole instruction.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			slot   <= stp_slot;
			degree <= stp_degree;
		end
	end

	a_done_busy: assert property (@(posedge clk) disable iff (!rst) done |-> busy)
		else $error("poly_dispatch saw done with no instruction in flight");

endmodule

//--- source/poly_coproc.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Polynomial coprocessor top level.
// Dispatch, STP engine, buffer, coefficient and
// degree RAMs, result and status FIFOs.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "poly_settings.svh"

module poly_coproc (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stp_start,
	input  poly_pkg::slot_t      stp_slot,
	input  poly_pkg::degree_t    stp_degree,
	input  logic                 cursor_clr,
	output logic                 busy,
	input  logic                 load_en,                     // Buffer load port.
	input  poly_pkg::buf_addr_t  load_addr,
	input  poly_pkg::coeff_t     load_data,
	input  poly_pkg::s_addr_t    s_rd_addr,                   // Coefficient readback.
	output poly_pkg::coeff_t     s_rd_data,
	input  poly_pkg::slot_t      n_rd_addr,                   // Degree readback.
	output poly_pkg::degree_t    n_rd_data,
	input  logic                 result_pop,
	output poly_pkg::fifo_word_t result_data,
	output logic                 result_empty,
	input  logic                 status_pop,
	output poly_pkg::fifo_word_t status_data,
	output logic                 status_empty
);
	import poly_pkg::*;

	logic       go;
	slot_t      slot;
	degree_t    degree;
	buf_addr_t  cursor;
	logic       done;
	buf_addr_t  cursor_next;
	logic       buf_rd_en;
	buf_addr_t  buf_rd_addr;
	coeff_t     buf_rd_data;
	logic       s_wr_en;
	s_addr_t    s_wr_addr;
	coeff_t     s_wr_data;
	logic       n_wr_en;
	slot_t      n_wr_addr;
	degree_t    n_wr_data;
	logic       result_push;
	logic       status_push;
	fifo_word_t result_word;
	fifo_word_t status_word;

	poly_dispatch u_dispatch (.clk, .rst, .stp_start, .stp_slot, .stp_degree, .cursor_clr,
		.done, .cursor_next, .go, .slot, .degree, .cursor, .busy);

	stp_engine u_engine (.clk, .rst, .go, .slot, .degree, .cursor, .buf_rd_data,
		.buf_rd_en, .buf_rd_addr, .s_wr_en, .s_wr_addr, .s_wr_data, .n_wr_en, .n_wr_addr,
		.n_wr_data, .result_push, .status_push, .result_word, .status_word, .done,
		.cursor_next);

	// Host writes, engine reads.
	poly_ram #(.payload_t(coeff_t), .DEPTH(`POLY_BUF_DEPTH)) u_buf_ram (.clk,
		.wr_en(load_en), .wr_addr(load_addr), .wr_data(load_data),
		.rd_en(buf_rd_en), .rd_addr(buf_rd_addr), .rd_data(buf_rd_data));

	// Engine writes, host reads every cycle.
	poly_ram #(.payload_t(coeff_t), .DEPTH(`POLY_SLOTS * `POLY_SLOT_WORDS)) u_s_ram (.clk,
		.wr_en(s_wr_en), .wr_addr(s_wr_addr), .wr_data(s_wr_data),
		.rd_en(1'b1), .rd_addr(s_rd_addr), .rd_data(s_rd_data));

	poly_ram #(.payload_t(degree_t), .DEPTH(`POLY_SLOTS)) u_n_ram (.clk,
		.wr_en(n_wr_en), .wr_addr(n_wr_addr), .wr_data(n_wr_data),
		.rd_en(1'b1), .rd_addr(n_rd_addr), .rd_data(n_rd_data));

	poly_fifo #(.DEPTH(`POLY_FIFO_DEPTH)) u_result_fifo (.clk, .rst, .push(result_push),
		.push_data(result_word), .pop(result_pop), .head_data(result_data),
		.empty(result_empty));

	poly_fifo #(.DEPTH(`POLY_FIFO_DEPTH)) u_status_fifo (.clk, .rst, .push(status_push),
		.push_data(status_word), .pop(status_pop), .head_data(status_data),
		.empty(status_empty));

endmodule

//--- dv/tb_poly_coproc.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Polynomial coprocessor testbench.
// Random STP stimulus checked against a model of
// the buffer, slots, cursor and FIFO words.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "poly_settings.svh"

module tb_poly_coproc;
	import poly_pkg::*;

	localparam int LOAD_WORDS = 200;                         // Buffer words loaded.
	localparam int NUM_INSTR = 24;                           // Starts issued, dropped one too.
	localparam int WATCHDOG_CYCLES = NUM_INSTR * 20 + LOAD_WORDS + 1000;

	logic       clk;
	logic       rst;
	logic       stp_start;
	slot_t      stp_slot;
	degree_t    stp_degree;
	logic       cursor_clr;
	logic       busy;
	logic       load_en;
	buf_addr_t  load_addr;
	coeff_t     load_data;
	s_addr_t    s_rd_addr;
	coeff_t     s_rd_data;
	slot_t      n_rd_addr;
	degree_t    n_rd_data;
	logic       result_pop;
	fifo_word_t result_data;
	logic       result_empty;
	logic       status_pop;
	fifo_word_t status_data;
	logic       status_empty;

	coeff_t     buf_model [`POLY_BUF_DEPTH];                 // Mirror of every load.
	coeff_t     coeff_model [`POLY_SLOTS * `POLY_SLOT_WORDS];
	degree_t    deg_model [`POLY_SLOTS];
	bit         written [`POLY_SLOTS];                       // Slot holds a known polynomial.
	int         cur_model;                                   // Model buffer cursor.
	fifo_word_t exp_result [$];
	fifo_word_t exp_status [$];
	integer     seed = 32'hfef5_bd41;
	integer     r;
	int         errors;
	int         checks;
	int         tests;
	int         test_start_errors;
	string      test_name;
	slot_t      a;

	poly_coproc uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;                           // 4 ns period.
	end

	// Watchdog sized from the instruction count and the load.
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks and test bookkeeping.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			$display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string msg);
		checks++;
		assert (cond)
		else
		begin
			$display("ERROR %s: %s", test_name, msg);  // Non-value failure.
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errors = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s: %s", test_name, (errors == test_start_errors) ? "ok" : "failed");
	endtask

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and host actions.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// STP rule: legal degree copies N+1 words and moves the cursor.
	task automatic model_stp(input slot_t slot, input degree_t n);
		if (n <= `POLY_MAX_DEGREE)
		begin
			deg_model[slot] = n;
			written[slot] = 1'b1;
			for (int i = 0; i <= n; i++)
				coeff_model[slot * `POLY_SLOT_WORDS + i] = buf_model[cur_model + i];
			cur_model = cur_model + n + 1;
			exp_result.push_back(32'd1);
			exp_status.push_back(32'd0);
		end
		else
		begin
			exp_result.push_back(32'd0);         // Nothing written.
			exp_status.push_back(32'd1);
		end
	endtask

	task automatic load_buffer(input int words);
		for (int i = 0; i < words; i++)
		begin
			@(negedge clk);
			r = $random(seed);
			load_en = 1'b1;
			load_addr = buf_addr_t'(i);
			load_data = coeff_t'(r);
			buf_model[i] = coeff_t'(r);
		end
		@(negedge clk);
		load_en = 1'b0;
	endtask

	task automatic wait_idle();
		while (busy)
			@(negedge clk);                          // Busy falls after done.
	endtask

	task automatic issue_stp(input slot_t slot, input degree_t n);
		@(negedge clk);
		stp_start = 1'b1;
		stp_slot = slot;
		stp_degree = n;
		@(negedge clk);
		stp_start = 1'b0;
		check_true(busy, "busy did not rise after an accepted stp_start");
		model_stp(slot, n);
		wait_idle();
	endtask

	// Degree and N+1 coefficients of one slot.
	task automatic read_slot(input slot_t slot);
		@(negedge clk);
		n_rd_addr = slot;
		@(negedge clk);
		check("degree", deg_model[slot], n_rd_data);
		for (int k = 0; k <= deg_model[slot]; k++)
		begin
			@(negedge clk);
			s_rd_addr = s_addr_t'(slot * `POLY_SLOT_WORDS + k);
			@(negedge clk);
			check("coefficient", coeff_model[slot * `POLY_SLOT_WORDS + k], s_rd_data);
		end
	endtask

	task automatic drain_fifos();
		while (exp_result.size() > 0)
		begin
			@(negedge clk);
			check_true(!result_empty && !status_empty, "a FIFO was empty with words expected");
			check("result word", exp_result.pop_front(), result_data);
			check("status word", exp_status.pop_front(), status_data);
			result_pop = !result_empty;
			status_pop = !status_empty;
			@(negedge clk);
			result_pop = 1'b0;
			status_pop = 1'b0;
		end
		@(negedge clk);
		check_true(result_empty && status_empty, "a FIFO held more words than issued");
	endtask

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		rst = 1'b0;
		stp_start = 1'b0;
		stp_slot = '0;
		stp_degree = '0;
		cursor_clr = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		s_rd_addr = '0;
		n_rd_addr = '0;
		result_pop = 1'b0;
		status_pop = 1'b0;
		cur_model = 0;
		repeat (3) @(posedge clk);                       // Reset held 3 cycles.
		@(negedge clk);
		rst = 1'b1;

		begin_test("reset_state");
		@(negedge clk);
		check_true(result_empty && status_empty, "a FIFO was not empty after reset");
		check("busy", 32'd0, busy);
		end_test();

		begin_test("legal_stp");
		load_buffer(LOAD_WORDS);
		for (int i = 0; i < 10; i++)
		begin
			r = $random(seed);
			a = slot_t'(r);
			issue_stp(a, degree_t'($unsigned(r >>> 8) % 11));
			read_slot(a);
		end
		drain_fifos();
		end_test();

		begin_test("illegal_degree");
		for (int i = 0; i < 4; i++)
		begin
			r = $random(seed);
			a = slot_t'(r);
			issue_stp(a, degree_t'(11 + $unsigned(r >>> 8) % 21));
			if (written[a])
				read_slot(a);                    // Contents unchanged.
		end
		r = $random(seed);
		a = slot_t'(r);
		issue_stp(a, degree_t'($unsigned(r >>> 8) % 11));   // Copies from the old cursor.
		read_slot(a);
		drain_fifos();
		end_test();

		begin_test("mixed_fifo_order");
		for (int i = 0; i < 6; i++)
		begin
			r = $random(seed);
			if (r[16])
				issue_stp(slot_t'(r), degree_t'($unsigned(r >>> 8) % 11));
			else
				issue_stp(slot_t'(r), degree_t'(11 + $unsigned(r >>> 8) % 21));
		end
		drain_fifos();
		end_test();

		begin_test("busy_drop_cursor_clr");
		r = $random(seed);
		a = slot_t'(r);
		@(negedge clk);
		stp_start = 1'b1;
		stp_slot = a;
		stp_degree = degree_t'($unsigned(r >>> 8) % 11);
		model_stp(a, stp_degree);
		@(negedge clk);
		check_true(busy, "busy did not rise after an accepted stp_start");
		stp_slot = a + 1'b1;                             // Second start, engine busy.
		stp_degree = 5'd10;
		@(negedge clk);
		stp_start = 1'b0;
		wait_idle();
		read_slot(a);
		if (written[a + 1'b1])
			read_slot(a + 1'b1);
		drain_fifos();                                   // One word pair only.
		@(negedge clk);
		cursor_clr = 1'b1;
		@(negedge clk);
		cursor_clr = 1'b0;
		cur_model = 0;                                   // Rewind to buffer word 0.
		r = $random(seed);
		a = slot_t'(r);
		issue_stp(a, degree_t'($unsigned(r >>> 8) % 11));
		read_slot(a);
		drain_fifos();
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
source/poly_pkg.sv
source/poly_ram.sv
source/poly_fifo.sv
source/stp_engine.sv
source/poly_dispatch.sv
source/poly_coproc.sv
dv/tb_poly_coproc.sv

//--- Bender.yml
package:
  name: poly_coproc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/poly_pkg.sv
      - source/poly_ram.sv
      - source/poly_fifo.sv
      - source/stp_engine.sv
      - source/poly_dispatch.sv
      - source/poly_coproc.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_poly_coproc.sv
